// ==== hdl/host_params.svh ====
`ifndef HOST_PARAMS_SVH
`define HOST_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 16 KiB of RAM at 0000 - 3FFF
`define HOST_RAM_AWIDTH 14
// Address bits that must be zero for a RAM hit
`define HOST_RAM_TOP 15:14

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// I/O map, decoded on the high address byte
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define HOST_IO_UART_DATA 8'h00
`define HOST_IO_UART_STAT 8'h02

// Clocks per serial bit, kept short for simulation
`define HOST_BAUD_DIV 8
// Value seen on a read that hits nothing
`define HOST_IDLE_DATA 8'hFF

`endif

// ==== hdl/hostBusPkg.sv ====
`include "host_params.svh"

package hostBusPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Plain bus widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [15:0] cpuAddr_t;
    typedef logic [7:0] cpuData_t;
    typedef logic [`HOST_RAM_AWIDTH-1:0] ramAddr_t;

    // CPU pins as seen by the board, strobes active low
    typedef struct packed {
        cpuAddr_t addr;
        cpuData_t wdata;
        logic     nMreq;
        logic     nIorq;
        logic     nRd;
        logic     nWr;
    } cpuBus_t;

    // One decoded access, valid for a single clock
    typedef struct packed {
        logic     valid;
        logic     rd;
        logic     wr;
        logic     ramSel;
        logic     uartDataSel;
        logic     uartStatSel;
        ramAddr_t ramAddr;
        cpuData_t wdata;
    } busReq_t;

endpackage

// ==== hdl/uartPkg.sv ====
`include "host_params.svh"

package uartPkg;

    // Byte handed to the transmitter
    typedef logic [7:0] uartByte_t;

    // Counts the data bits of a frame
    typedef logic [3:0] bitCount_t;

    // Wide enough to count up to HOST_BAUD_DIV - 1
    typedef logic [$clog2(`HOST_BAUD_DIV)-1:0] baudCount_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Transmitter FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // IDLE  line high, waiting for a byte
    // START one bit time low
    // DATA  eight bits, LSB first
    // STOP  one bit time high
    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } txState_t;

endpackage

// ==== hdl/busDecode.sv ====
`timescale 1ns/1ns
`include "host_params.svh"

module busDecode import hostBusPkg::*; (
    input  logic    clk,
    input  logic    arstN,
    input  cpuBus_t cpuBus,
    output busReq_t busReq
);

    // Bus at rest with all strobes released
    localparam cpuBus_t BUS_IDLE = '{addr: '0, wdata: '0, nMreq: 1'b1, nIorq: 1'b1,
                                     nRd: 1'b1, nWr: 1'b1};

    cpuBus_t busSample;
    logic    accessOpen;
    logic    memAcc;
    logic    ioAcc;
    logic    strobeOn;
    logic    accStart;
    busReq_t nextReq;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pin sampling
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            busSample <= BUS_IDLE;
        end else begin
            busSample <= cpuBus;
        end
    end

    // Memory cycles win over I/O if both strobes show up
    assign memAcc   = !busSample.nMreq;
    assign ioAcc    = !busSample.nIorq && busSample.nMreq;
    assign strobeOn = (memAcc || ioAcc) && (!busSample.nRd || !busSample.nWr);
    // First active cycle only
    assign accStart = strobeOn && !accessOpen;

    // Held open until both rd and wr are back high
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            accessOpen <= 1'b0;
        end else if (accStart) begin
            accessOpen <= 1'b1;
        end else if (busSample.nRd && busSample.nWr) begin
            accessOpen <= 1'b0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        nextReq             = '0;
        nextReq.valid       = accStart;
        nextReq.rd          = !busSample.nRd;
        nextReq.wr          = !busSample.nWr;
        // RAM only in the low 16K of memory space
        nextReq.ramSel      = memAcc && (busSample.addr[`HOST_RAM_TOP] == '0);
        // I/O selects look at the high address byte
        nextReq.uartDataSel = ioAcc && (busSample.addr[15:8] == `HOST_IO_UART_DATA);
        nextReq.uartStatSel = ioAcc && (busSample.addr[15:8] == `HOST_IO_UART_STAT);
        nextReq.ramAddr     = busSample.addr[`HOST_RAM_AWIDTH-1:0];
        nextReq.wdata       = busSample.wdata;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            busReq <= '0;
        end else begin
            busReq <= nextReq;
        end
    end

    // The CPU never reads and writes in one access
    assert property (@(posedge clk) disable iff (!arstN)
        busReq.valid |-> !(busReq.rd && busReq.wr));

    assert property (@(posedge clk) disable iff (!arstN)
        busReq.valid |-> $onehot0({busReq.ramSel, busReq.uartDataSel, busReq.uartStatSel}));

endmodule

// ==== hdl/ram16k.sv ====
`timescale 1ns/1ns
`include "host_params.svh"

module ram16k import hostBusPkg::*; (
    input  logic     clk,
    input  busReq_t  busReq,
    output cpuData_t ramRdata
);

    localparam int RAM_DEPTH = 2 ** `HOST_RAM_AWIDTH;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Storage, single port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    cpuData_t mem [RAM_DEPTH];

    logic ramWe;

    // Only a decoded memory write in range
    assign ramWe = busReq.valid && busReq.wr && busReq.ramSel;

    always_ff @(posedge clk) begin
        if (ramWe) begin
            mem[busReq.ramAddr] <= busReq.wdata;
        end
    end

    // Read every cycle
    // data lines up one clock behind the request
    always_ff @(posedge clk) begin
        ramRdata <= mem[busReq.ramAddr];
    end

endmodule

// ==== hdl/uartTx.sv ====
`timescale 1ns/1ns
`include "host_params.svh"

module uartTx import hostBusPkg::*, uartPkg::*; (
    input  logic    clk,
    input  logic    arstN,
    input  busReq_t busReq,
    output logic    busy,
    output logic    txd
);

    localparam baudCount_t BAUD_LAST = baudCount_t'(`HOST_BAUD_DIV - 1);
    localparam bitCount_t  DATA_LAST = bitCount_t'(7);

    txState_t   state;
    baudCount_t baudCnt;
    bitCount_t  bitCnt;
    uartByte_t  shiftReg;
    logic       accept;
    logic       baudEnd;

    // Writes while a frame is out are simply lost
    assign accept  = busReq.valid && busReq.wr && busReq.uartDataSel && (state == IDLE);
    assign baudEnd = (baudCnt == BAUD_LAST);

    // Data byte shifted right once per data bit
    always_ff @(posedge clk) begin
        if (accept) begin
            shiftReg <= uartByte_t'(busReq.wdata);
        end else if (state == DATA && baudEnd) begin
            shiftReg <= shiftReg >> 1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state   <= IDLE;
            baudCnt <= '0;
            bitCnt  <= '0;
            txd     <= 1'b1;
            busy    <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        // Start bit goes out right away
                        state   <= START;
                        baudCnt <= '0;
                        bitCnt  <= '0;
                        txd     <= 1'b0;
                        busy    <= 1'b1;
                    end
                end
                START: begin
                    if (baudEnd) begin
                        state   <= DATA;
                        baudCnt <= '0;
                        txd     <= shiftReg[0];
                    end else begin
                        baudCnt <= baudCnt + 1'b1;
                    end
                end
                DATA: begin
                    if (baudEnd) begin
                        baudCnt <= '0;
                        if (bitCnt == DATA_LAST) begin
                            state <= STOP;
                            txd   <= 1'b1;
                        end else begin
                            // Bit 1 is the next one after this shift
                            bitCnt <= bitCnt + 1'b1;
                            txd    <= shiftReg[1];
                        end
                    end else begin
                        baudCnt <= baudCnt + 1'b1;
                    end
                end
                STOP: begin
                    if (baudEnd) begin
                        // Frame done and busy drops with it
                        state <= IDLE;
                        busy  <= 1'b0;
                    end else begin
                        baudCnt <= baudCnt + 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                    txd   <= 1'b1;
                    busy  <= 1'b0;
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!arstN)
        busy == (state != IDLE));

endmodule

// ==== hdl/readReturn.sv ====
`timescale 1ns/1ns
`include "host_params.svh"

module readReturn import hostBusPkg::*; (
    input  logic     clk,
    input  logic     arstN,
    input  busReq_t  busReq,
    input  cpuData_t ramRdata,
    input  logic     busy,
    output cpuData_t rdata
);

    logic     rdPend;
    logic     pendRam;
    logic     pendStat;
    cpuData_t statByte;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Align the read with RAM output
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rdPend   <= 1'b0;
            pendRam  <= 1'b0;
            pendStat <= 1'b0;
        end else begin
            rdPend   <= busReq.valid && busReq.rd;
            pendRam  <= busReq.ramSel;
            pendStat <= busReq.uartStatSel;
        end
    end

    // Status byte, busy in bit 0
    assign statByte = {7'b0, busy};

    // Held until the next read comes along
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rdata <= `HOST_IDLE_DATA;
        end else if (rdPend) begin
            if (pendRam) begin
                rdata <= ramRdata;
            end else if (pendStat) begin
                rdata <= statByte;
            end else begin
                // Unmapped, also the write only data port
                rdata <= `HOST_IDLE_DATA;
            end
        end
    end

endmodule

// ==== hdl/hostBoard.sv ====
`timescale 1ns/1ns

module hostBoard import hostBusPkg::*; (
    input  logic     clk,
    input  logic     arstN,
    input  cpuBus_t  cpuBus,
    output cpuData_t rdata,
    output logic     txd
);

    // Decoded request shared by all of stage 2 and 3
    busReq_t  busReq;
    cpuData_t ramRdata;
    logic     busy;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage 1, decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    busDecode uBusDecode (
        .clk    (clk),
        .arstN  (arstN),
        .cpuBus (cpuBus),
        .busReq (busReq)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage 2, peripherals
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    ram16k uRam (
        .clk      (clk),
        .busReq   (busReq),
        .ramRdata (ramRdata)
    );

    // Serial out, busy goes back through the status read
    uartTx uUartTx (
        .clk    (clk),
        .arstN  (arstN),
        .busReq (busReq),
        .busy   (busy),
        .txd    (txd)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage 3, read data back to the CPU
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    readReturn uReadReturn (
        .clk      (clk),
        .arstN    (arstN),
        .busReq   (busReq),
        .ramRdata (ramRdata),
        .busy     (busy),
        .rdata    (rdata)
    );

endmodule

// ==== bench/hostBoardTb.sv ====
`timescale 1ns/1ns
`include "host_params.svh"

module hostBoardTb import hostBusPkg::*, uartPkg::*; #(
    parameter bit [31:0] SEED = 32'hb6f4_66c6
);

    localparam int CLK_PERIOD    = 100;
    localparam int FRAME_CYCLES  = 10 * `HOST_BAUD_DIV;
    // Eight strobe cycles plus one idle cycle per access
    localparam int ACCESS_CYCLES = 9;
    localparam int NUM_RAM       = 64;
    localparam int BUS_OPS       = 2 * NUM_RAM + 40;
    localparam int UART_FRAMES   = 4;
    // Twice the planned run length, plus reset
    localparam int WATCH_CYCLES  =
        2 * (BUS_OPS * ACCESS_CYCLES + UART_FRAMES * FRAME_CYCLES) + 100;

    // One finished read, kept until the compare process sees it
    typedef struct packed {
        cpuAddr_t addr;
        cpuData_t expData;
        cpuData_t gotData;
    } readResult_t;

    logic     clk;
    logic     arstN;
    cpuBus_t  cpuBus;
    cpuData_t rdata;
    logic     txd;

    int          seed;
    int unsigned cycleCnt;
    int          readsIssued;
    int          readsChecked;
    // Reference RAM image and UART timing
    cpuData_t    ramImg [ramAddr_t];
    logic        uartUsed;
    int unsigned uartStart;
    uartByte_t   rxQ [$];
    readResult_t resultQ [$];

    hostBoard i_dut (
        .clk    (clk),
        .arstN  (arstN),
        .cpuBus (cpuBus),
        .rdata  (rdata),
        .txd    (txd)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Edge counter for the busy model
    always @(posedge clk) cycleCnt <= cycleCnt + 1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Busy after edge n, one frame from the last accepted byte
    function automatic logic busyAt(input int unsigned n);
        return uartUsed && (n >= uartStart) && (n < uartStart + FRAME_CYCLES);
    endfunction

    function automatic cpuData_t expectRead(input cpuAddr_t addr, input logic isIo,
                                            input logic busyNow);
        ramAddr_t low;
        low = addr[`HOST_RAM_AWIDTH-1:0];
        if (!isIo) begin
            // Low 16K only, rest of memory space floats to idle
            if (addr[`HOST_RAM_TOP] == '0) begin
                return ramImg[low];
            end
            return `HOST_IDLE_DATA;
        end
        if (addr[15:8] == `HOST_IO_UART_STAT) begin
            return {7'b0, busyNow};
        end
        return `HOST_IDLE_DATA;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic checkData(input string name, input cpuData_t got, input cpuData_t exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
            $display("Testbench failed");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic checkByte(input string name, input uartByte_t got, input uartByte_t exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
            $display("Testbench failed");
            $fatal(1, "serial byte mismatch");
        end
    endtask

    task automatic checkLevel(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
            $display("Testbench failed");
            $fatal(1, "level mismatch");
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // CPU bus model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic busAccess(input logic isIo, input logic isRd, input cpuAddr_t addr,
                             input cpuData_t data);
        readResult_t res;
        int unsigned issue;
        res = '0;
        @(posedge clk);
        #10;
        issue        = cycleCnt;
        cpuBus.addr  = addr;
        cpuBus.wdata = data;
        cpuBus.nMreq = isIo;
        cpuBus.nIorq = !isIo;
        cpuBus.nRd   = !isRd;
        cpuBus.nWr   = isRd;
        if (isRd) begin
            // Status reflects busy three edges after the strobe
            res.addr    = addr;
            res.expData = expectRead(addr, isIo, busyAt(issue + 3));
            readsIssued++;
        end else if (isIo && addr[15:8] == `HOST_IO_UART_DATA) begin
            // Byte taken only if the line is free at decode time
            if (!busyAt(issue + 2)) begin
                uartUsed  = 1'b1;
                uartStart = issue + 3;
            end
        end else if (!isIo && addr[`HOST_RAM_TOP] == '0) begin
            ramImg[addr[`HOST_RAM_AWIDTH-1:0]] = data;
        end
        repeat (8) @(posedge clk);
        #10;
        if (isRd) begin
            res.gotData = rdata;
            resultQ.push_back(res);
        end
        cpuBus.nMreq = 1'b1;
        cpuBus.nIorq = 1'b1;
        cpuBus.nRd   = 1'b1;
        cpuBus.nWr   = 1'b1;
    endtask

    task automatic memWrite(input cpuAddr_t addr, input cpuData_t data);
        busAccess(1'b0, 1'b0, addr, data);
    endtask

    task automatic memRead(input cpuAddr_t addr);
        busAccess(1'b0, 1'b1, addr, 8'h00);
    endtask

    task automatic ioWrite(input cpuAddr_t addr, input cpuData_t data);
        busAccess(1'b1, 1'b0, addr, data);
    endtask

    task automatic ioRead(input cpuAddr_t addr);
        busAccess(1'b1, 1'b1, addr, 8'h00);
    endtask

    // Checks every finished read against the model
    initial begin
        readResult_t res;
        readsChecked = 0;
        forever begin
            @(posedge clk);
            while (resultQ.size() > 0) begin
                res = resultQ.pop_front();
                checkData($sformatf("rdata[%h]", res.addr), res.gotData, res.expData);
                readsChecked++;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Serial monitor, samples mid bit
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        uartByte_t rxByte;
        rxByte = '0;
        wait (arstN === 1'b1);
        forever begin
            @(negedge txd);
            repeat (`HOST_BAUD_DIV / 2) @(posedge clk);
            if (txd !== 1'b0) begin
                $display("Start bit on txd did not stay low to its centre");
                $display("Testbench failed");
                $fatal(1, "serial framing");
            end
            // LSB first
            for (int i = 0; i < 8; i++) begin
                repeat (`HOST_BAUD_DIV) @(posedge clk);
                rxByte[i] = txd;
            end
            repeat (`HOST_BAUD_DIV) @(posedge clk);
            if (txd !== 1'b1) begin
                $display("Serial frame ended without a high stop bit");
                $display("Testbench failed");
                $fatal(1, "serial framing");
            end
            rxQ.push_back(rxByte);
        end
    end

    initial begin
        #(WATCH_CYCLES * CLK_PERIOD);
        $display("Run timed out after %0d clock cycles", WATCH_CYCLES);
        $display("Testbench failed");
        $fatal(1, "timeout");
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        cpuAddr_t addrList [NUM_RAM];
        cpuAddr_t tmpAddr;
        cpuAddr_t hiAddr;
        cpuData_t val;
        int       j;
        seed        = int'(SEED);
        cycleCnt    = 0;
        readsIssued = 0;
        uartUsed    = 1'b0;
        uartStart   = 0;
        arstN       = 1'b0;
        cpuBus      = '{addr: '0, wdata: '0, nMreq: 1'b1, nIorq: 1'b1, nRd: 1'b1, nWr: 1'b1};
        repeat (4) @(posedge clk);
        #10;
        arstN = 1'b1;

        // Idle state straight out of reset
        @(posedge clk);
        #10;
        checkLevel("txd", txd, 1'b1);
        checkData("rdata", rdata, `HOST_IDLE_DATA);

        // Random RAM fill, read back in shuffled order
        for (int i = 0; i < NUM_RAM; i++) begin
            tmpAddr     = cpuAddr_t'($random(seed)) & 16'h3FFF;
            addrList[i] = tmpAddr;
            memWrite(tmpAddr, cpuData_t'($random(seed)));
        end
        for (int i = NUM_RAM - 1; i > 0; i--) begin
            j           = ($random(seed) & 32'h7fff_ffff) % (i + 1);
            tmpAddr     = addrList[i];
            addrList[i] = addrList[j];
            addrList[j] = tmpAddr;
        end
        for (int i = 0; i < NUM_RAM; i++) begin
            memRead(addrList[i]);
        end

        // Above 3FFF, reads idle and writes must not alias into RAM
        for (int i = 0; i < 4; i++) begin
            tmpAddr = cpuAddr_t'($random(seed)) & 16'h3FFF;
            val     = cpuData_t'($random(seed));
            memWrite(tmpAddr, val);
            hiAddr = tmpAddr | cpuAddr_t'((i % 3 + 1) << 14);
            memWrite(hiAddr, ~val);
            memRead(hiAddr);
            memRead(tmpAddr);
        end
        memRead(16'hFFFF);

        // UART frames, busy status and a dropped write
        checkLevel("txd", txd, 1'b1);
        for (int i = 0; i < 3; i++) begin
            val = cpuData_t'($random(seed));
            ioWrite({`HOST_IO_UART_DATA, cpuData_t'($random(seed))}, val);
            ioRead({`HOST_IO_UART_STAT, 8'h10});
            if (i == 0) begin
                ioWrite({`HOST_IO_UART_DATA, 8'h55}, ~val);
            end
            repeat (FRAME_CYCLES + 10) @(posedge clk);
            ioRead({`HOST_IO_UART_STAT, 8'hA5});
            checkLevel("txd", txd, 1'b1);
            if (rxQ.size() != 1) begin
                $display("Expected one serial frame, monitor holds %0d", rxQ.size());
                $display("Testbench failed");
                $fatal(1, "frame count");
            end
            checkByte("txByte", rxQ.pop_front(), val);
        end

        // Other I/O codes idle
        ioRead(16'h0155);
        ioRead(16'h0300);
        ioRead(16'hFF00);

        repeat (3) @(posedge clk);
        if (readsChecked != readsIssued) begin
            $display("Only %0d of %0d reads reached the compare", readsChecked, readsIssued);
            $display("Testbench failed");
            $fatal(1, "reads lost");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

// ==== src.f ====
+incdir+hdl
hdl/hostBusPkg.sv
hdl/uartPkg.sv
hdl/busDecode.sv
hdl/ram16k.sv
hdl/uartTx.sv
hdl/readReturn.sv
hdl/hostBoard.sv
bench/hostBoardTb.sv

// ==== Makefile ====
# Verilator flow for the host board testbench

TOP       ?= hostBoardTb
SEED      ?= 3069470406
LOG       ?= sim.log
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ns -Wno-fatal
FILELIST  ?= src.f

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) \
		-f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

# The log decides the result, not the simulator exit code
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
